// ==== dv/memsys_tests.txt ====
// mode port we addr sel wdata expect  (mode 0 single, 1 pair with next line, f end)
// expect is the read value, ignored for writes
0 0 1 10 f 12345678 00000000
0 0 0 10 f 00000000 12345678
0 0 1 20 f a5a5a5a5 00000000
0 0 1 20 5 11223344 00000000
0 0 0 20 f 00000000 a522a544
0 1 1 21 f cafef00d 00000000
0 1 1 21 a deadbeef 00000000
0 1 0 21 f 00000000 defebe0d
1 0 1 30 f 0badf00d 00000000
0 1 1 31 f 600dcafe 00000000
0 0 0 30 f 00000000 0badf00d
0 1 0 31 f 00000000 600dcafe
0 0 1 40 f 13579bdf 00000000
0 1 0 40 f 00000000 13579bdf
1 0 0 31 f 00000000 600dcafe
0 1 0 30 f 00000000 0badf00d
1 0 1 41 f 2468ace0 00000000
0 1 0 10 f 00000000 12345678
0 1 0 41 f 00000000 2468ace0
1 1 1 50 f 89abcdef 00000000
0 0 0 20 f 00000000 a522a544
0 0 0 50 f 00000000 89abcdef
f 0 0 00 0 00000000 00000000

// ==== dv/tb_memsys.sv ====
// Testbench for the shared memory system: file-driven transactions on both host ports
module tb_memsys;

	// Test record layout: mode port we addr sel wdata expect
	localparam int FIELDS    = 7;
	localparam int MAX_LINES = 64;

	logic sys_clk;
	logic rst1;

	// Host port 0
	logic                  p0_req;
	logic                  p0_we;
	memsys_pkg::mem_addr_t p0_addr;
	memsys_pkg::mem_sel_t  p0_sel;
	memsys_pkg::mem_word_t p0_wdata;
	logic                  p0_ack;
	memsys_pkg::mem_word_t p0_rdata;

	// Host port 1
	logic                  p1_req;
	logic                  p1_we;
	memsys_pkg::mem_addr_t p1_addr;
	memsys_pkg::mem_sel_t  p1_sel;
	memsys_pkg::mem_word_t p1_wdata;
	logic                  p1_ack;
	memsys_pkg::mem_word_t p1_rdata;

	// Flat record store, FIELDS words per line
	logic [31:0] test_mem [MAX_LINES*FIELDS];

	int cycle_cnt   = 0;
	int cycle_limit = 0;

	memsys_top dut0 (
		.sys_clk    (sys_clk),
		.rst1       (rst1),
		.p0_req_i   (p0_req),
		.p0_we_i    (p0_we),
		.p0_addr_i  (p0_addr),
		.p0_sel_i   (p0_sel),
		.p0_wdata_i (p0_wdata),
		.p0_ack_o   (p0_ack),
		.p0_rdata_o (p0_rdata),
		.p1_req_i   (p1_req),
		.p1_we_i    (p1_we),
		.p1_addr_i  (p1_addr),
		.p1_sel_i   (p1_sel),
		.p1_wdata_i (p1_wdata),
		.p1_ack_o   (p1_ack),
		.p1_rdata_o (p1_rdata)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// ------------------------------------------------------------------------
	// Reporting and checks
	// ------------------------------------------------------------------------
	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_rdata(input string name, input memsys_pkg::mem_word_t got,
			input memsys_pkg::mem_word_t exp);
		if (got !== exp) begin
			fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_ack(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
		end
	endtask

	// Watchdog, limit set once the test file is known
	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			fail_now($sformatf("Timeout: tests not done after %0d cycles", cycle_cnt));
		end
	end

	// ------------------------------------------------------------------------
	// Port access
	// ------------------------------------------------------------------------
	function automatic logic ack_of(input int port);
		return (port == 0) ? p0_ack : p1_ack;
	endfunction

	function automatic memsys_pkg::mem_word_t rdata_of(input int port);
		return (port == 0) ? p0_rdata : p1_rdata;
	endfunction

	task automatic drive_port(input int port, input logic req, input logic we,
			input memsys_pkg::mem_addr_t addr, input memsys_pkg::mem_sel_t sel,
			input memsys_pkg::mem_word_t wdata);
		if (port == 0) begin
			p0_req   = req;
			p0_we    = we;
			p0_addr  = addr;
			p0_sel   = sel;
			p0_wdata = wdata;
		end else begin
			p1_req   = req;
			p1_we    = we;
			p1_addr  = addr;
			p1_sel   = sel;
			p1_wdata = wdata;
		end
	endtask

	// One four-phase transaction, entered and left on a falling edge
	task automatic run_txn(input int line);
		int                    base;
		int                    port;
		int                    hold;
		int                    idle;
		logic                  we;
		memsys_pkg::mem_addr_t addr;
		memsys_pkg::mem_sel_t  sel;
		memsys_pkg::mem_word_t wdata;
		memsys_pkg::mem_word_t exp;
		memsys_pkg::mem_word_t held;
		string                 tag;
		base  = line * FIELDS;
		port  = int'(test_mem[base+1]);
		we    = test_mem[base+2][0];
		addr  = memsys_pkg::mem_addr_t'(test_mem[base+3]);
		sel   = memsys_pkg::mem_sel_t'(test_mem[base+4]);
		wdata = test_mem[base+5];
		exp   = test_mem[base+6];
		hold  = int'($urandom % 4);
		idle  = int'($urandom % 4);
		tag   = (port == 0) ? "p0" : "p1";
		drive_port(port, 1'b1, we, addr, sel, wdata);
		// Latency varies under contention
		do begin
			@(negedge sys_clk);
		end while (ack_of(port) !== 1'b1);
		held = rdata_of(port);
		if (!we) begin
			check_rdata($sformatf("%s_rdata_o", tag), held, exp);
		end
		// Host stretches req, result frozen
		repeat (hold) begin
			@(negedge sys_clk);
			check_ack($sformatf("%s_ack_o", tag), ack_of(port), 1'b1);
			check_rdata($sformatf("%s_rdata_o", tag), rdata_of(port), held);
		end
		drive_port(port, 1'b0, we, addr, sel, wdata);
		@(negedge sys_clk);
		check_ack($sformatf("%s_ack_o", tag), ack_of(port), 1'b0);
		repeat (idle) @(negedge sys_clk);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial begin
		int n_lines;
		int line;
		rst1 = 1'b0;
		drive_port(0, 1'b0, 1'b0, '0, '0, '0);
		drive_port(1, 1'b0, 1'b0, '0, '0, '0);
		void'($urandom(32'hf5d2_60a0));
		$readmemh("dv/memsys_tests.txt", test_mem);
		n_lines = 0;
		while (n_lines < MAX_LINES && test_mem[n_lines*FIELDS] != 32'hf) begin
			n_lines++;
		end
		if (n_lines == 0 || n_lines == MAX_LINES) begin
			fail_now("Test file is empty or lacks its end record");
		end
		cycle_limit = 64 * n_lines + 100;
		// Both acks quiet through reset and the idle stretch after it
		repeat (16) begin
			@(negedge sys_clk);
			check_ack("p0_ack_o", p0_ack, 1'b0);
			check_ack("p1_ack_o", p1_ack, 1'b0);
		end
		rst1 = 1'b1;
		repeat (4) begin
			@(negedge sys_clk);
			check_ack("p0_ack_o", p0_ack, 1'b0);
			check_ack("p1_ack_o", p1_ack, 1'b0);
		end
		line = 0;
		while (line < n_lines) begin
			if (test_mem[line*FIELDS] == 32'h1) begin
				if (line + 1 >= n_lines) begin
					fail_now("Pair record has no second line");
				end
				if (test_mem[line*FIELDS+1] == test_mem[(line+1)*FIELDS+1]) begin
					fail_now("Pair record uses the same port twice");
				end
				// Both reqs rise on the same edge
				fork
					run_txn(line);
					run_txn(line + 1);
				join
				line += 2;
			end else if (test_mem[line*FIELDS] == 32'h0) begin
				run_txn(line);
				line++;
			end else begin
				fail_now($sformatf("Unknown mode in test line %0d", line));
			end
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+src
src/memsys_pkg.sv
src/mem_port_if.sv
src/port_bridge.sv
src/mem_arbiter.sv
src/sram_ctrl.sv
src/memsys_top.sv
dv/tb_memsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the memory system testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f list.f \
	--top-module tb_memsys \
	-Mdir obj_dir \
	-o sim_memsys
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/sim_memsys
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit "$status"
fi

exit 0

// ==== src/mem_arbiter.sv ====
// Fixed-priority two-port arbiter, grant locked until the memory ack, with assertions
`include "memsys_consts.svh"

module mem_arbiter (
	input  logic       sys_clk_i,
	input  logic       rst1_i,
	mem_port_if.slave  p0,
	mem_port_if.slave  p1,
	mem_port_if.master mem
);

	// Registered owner, OWN_NONE between transactions
	memsys_pkg::arb_owner_e owner_q;

	// Effective grant for this cycle
	memsys_pkg::arb_owner_e grant;

	// ---------------------------------------------------------------------------
	// Grant selection
	// ---------------------------------------------------------------------------
	always_comb begin
		grant = owner_q;
		// Only arbitrate from idle, port 0 first
		if (owner_q == memsys_pkg::OWN_NONE) begin
			if (p0.stb) begin
				grant = memsys_pkg::OWN_P0;
			end else if (p1.stb) begin
				grant = memsys_pkg::OWN_P1;
			end
		end
	end

	// Lock grant, drop it on ack
	always_ff @(posedge sys_clk_i) begin
		if (!rst1_i) begin
			owner_q <= memsys_pkg::OWN_NONE;
		end else if (mem.ack) begin
			owner_q <= memsys_pkg::OWN_NONE;
		end else begin
			owner_q <= grant;
		end
	end

	// ---------------------------------------------------------------------------
	// Command mux towards memory
	// ---------------------------------------------------------------------------
	always_comb begin
		mem.stb   = 1'b0;
		mem.we    = 1'b0;
		mem.addr  = '0;
		mem.sel   = '0;
		mem.wdata = '0;
		case (grant)
			memsys_pkg::OWN_P0: begin
				mem.stb   = p0.stb;
				mem.we    = p0.we;
				mem.addr  = p0.addr;
				mem.sel   = p0.sel;
				mem.wdata = p0.wdata;
			end
			memsys_pkg::OWN_P1: begin
				mem.stb   = p1.stb;
				mem.we    = p1.we;
				mem.addr  = p1.addr;
				mem.sel   = p1.sel;
				mem.wdata = p1.wdata;
			end
			default: begin
			end
		endcase
	end

	// Response only to the owner, loser sees zeros
	assign p0.ack   = mem.ack && (grant == memsys_pkg::OWN_P0);
	assign p1.ack   = mem.ack && (grant == memsys_pkg::OWN_P1);
	assign p0.rdata = (grant == memsys_pkg::OWN_P0) ? mem.rdata : '0;
	assign p1.rdata = (grant == memsys_pkg::OWN_P1) ? mem.rdata : '0;

	// ---------------------------------------------------------------------------
	// Checks
	// ---------------------------------------------------------------------------

	// Owner held from the grant through the memory ack
	a_owner_locked: assert property (@(posedge sys_clk_i) disable iff (!rst1_i)
		mem.ack |-> (owner_q != memsys_pkg::OWN_NONE)
			&& (owner_q == $past(owner_q, `MEMSYS_RD_LAT)));

	// Ack only to a bridge still strobing
	a_ack_p0_stb: assert property (@(posedge sys_clk_i) disable iff (!rst1_i)
		p0.ack |-> p0.stb);
	a_ack_p1_stb: assert property (@(posedge sys_clk_i) disable iff (!rst1_i)
		p1.ack |-> p1.stb);

endmodule

// ==== src/mem_port_if.sv ====
// Interface for strobe/acknowledge memory transactions with master and slave modports
interface mem_port_if;

	// Command side, driven by the master
	logic                  stb;
	logic                  we;
	memsys_pkg::mem_addr_t addr;
	memsys_pkg::mem_sel_t  sel;
	memsys_pkg::mem_word_t wdata;

	// Response side, driven by the slave
	// rdata only valid while ack is high
	memsys_pkg::mem_word_t rdata;
	logic                  ack;

	// Master holds stb and command steady until the ack pulse
	modport master (
		output stb,
		output we,
		output addr,
		output sel,
		output wdata,
		input  rdata,
		input  ack
	);

	// Slave answers with a one-cycle ack
	modport slave (
		input  stb,
		input  we,
		input  addr,
		input  sel,
		input  wdata,
		output rdata,
		output ack
	);

endinterface

// ==== src/memsys_consts.svh ====
// Memory system constants: address, depth, word, select widths and access latency
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// ---------------------------------------------------------------------------
// Memory geometry
// ---------------------------------------------------------------------------

// Word address width
`define MEMSYS_ADDR_W 8

// Number of words, one per address
`define MEMSYS_DEPTH 256

// Data word width
`define MEMSYS_DATA_W 32

// One select bit per byte lane
`define MEMSYS_SEL_W 4

// ---------------------------------------------------------------------------
// Timing
// ---------------------------------------------------------------------------

// Cycles from the first sampled strobe to the ack pulse
// Covers reads and writes alike
`define MEMSYS_RD_LAT 2

`endif

// ==== src/memsys_pkg.sv ====
// Package with word, address and select types plus bridge and arbiter state enums
`include "memsys_consts.svh"

package memsys_pkg;

	// -----------------------------------------------------------------------
	// Bus payload types
	// -----------------------------------------------------------------------

	// Word address into the shared memory
	typedef logic [`MEMSYS_ADDR_W-1:0] mem_addr_t;

	// One data word
	typedef logic [`MEMSYS_DATA_W-1:0] mem_word_t;

	// Byte lane selects, bit n enables byte n
	typedef logic [`MEMSYS_SEL_W-1:0] mem_sel_t;

	// -----------------------------------------------------------------------
	// State encodings
	// -----------------------------------------------------------------------

	// Host port bridge FSM
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		HOLD,
		RELEASE
	} bridge_state_e;

	// Current holder of the memory grant
	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_P0,
		OWN_P1
	} arb_owner_e;

endpackage

// ==== src/memsys_top.sv ====
// Top level: two host ports, their bridges, the priority arbiter and the shared memory
module memsys_top (
	input  logic                  sys_clk,
	input  logic                  rst1,
	// Host port 0, higher priority
	input  logic                  p0_req_i,
	input  logic                  p0_we_i,
	input  memsys_pkg::mem_addr_t p0_addr_i,
	input  memsys_pkg::mem_sel_t  p0_sel_i,
	input  memsys_pkg::mem_word_t p0_wdata_i,
	output logic                  p0_ack_o,
	output memsys_pkg::mem_word_t p0_rdata_o,
	// Host port 1
	input  logic                  p1_req_i,
	input  logic                  p1_we_i,
	input  memsys_pkg::mem_addr_t p1_addr_i,
	input  memsys_pkg::mem_sel_t  p1_sel_i,
	input  memsys_pkg::mem_word_t p1_wdata_i,
	output logic                  p1_ack_o,
	output memsys_pkg::mem_word_t p1_rdata_o
);

	// Bridge to arbiter links and the arbiter to memory link
	mem_port_if bus_p0 ();
	mem_port_if bus_p1 ();
	mem_port_if bus_mem ();

	// ---------------------------------------------------------------------------
	// Host bridges
	// ---------------------------------------------------------------------------
	port_bridge bridge0 (
		.sys_clk_i (sys_clk),
		.rst1_i    (rst1),
		.req_i     (p0_req_i),
		.we_i      (p0_we_i),
		.addr_i    (p0_addr_i),
		.sel_i     (p0_sel_i),
		.wdata_i   (p0_wdata_i),
		.ack_o     (p0_ack_o),
		.rdata_o   (p0_rdata_o),
		.bus       (bus_p0)
	);

	port_bridge bridge1 (
		.sys_clk_i (sys_clk),
		.rst1_i    (rst1),
		.req_i     (p1_req_i),
		.we_i      (p1_we_i),
		.addr_i    (p1_addr_i),
		.sel_i     (p1_sel_i),
		.wdata_i   (p1_wdata_i),
		.ack_o     (p1_ack_o),
		.rdata_o   (p1_rdata_o),
		.bus       (bus_p1)
	);

	// ---------------------------------------------------------------------------
	// Arbitration and memory
	// ---------------------------------------------------------------------------
	mem_arbiter arb0 (
		.sys_clk_i (sys_clk),
		.rst1_i    (rst1),
		.p0        (bus_p0),
		.p1        (bus_p1),
		.mem       (bus_mem)
	);

	sram_ctrl mem0 (
		.sys_clk_i (sys_clk),
		.rst1_i    (rst1),
		.bus       (bus_mem)
	);

endmodule

// ==== src/port_bridge.sv ====
// Host port bridge: four-phase req/ack to strobe/ack transaction, read result holding
module port_bridge (
	input  logic                  sys_clk_i,
	input  logic                  rst1_i,
	input  logic                  req_i,
	input  logic                  we_i,
	input  memsys_pkg::mem_addr_t addr_i,
	input  memsys_pkg::mem_sel_t  sel_i,
	input  memsys_pkg::mem_word_t wdata_i,
	output logic                  ack_o,
	output memsys_pkg::mem_word_t rdata_o,
	mem_port_if.master            bus
);

	memsys_pkg::bridge_state_e state_q;

	// Captured command, held for the whole bus transaction
	logic                  we_q;
	memsys_pkg::mem_addr_t addr_q;
	memsys_pkg::mem_sel_t  sel_q;
	memsys_pkg::mem_word_t wdata_q;

	// Read result, steady while ack_o is high
	memsys_pkg::mem_word_t rdata_q;

	// ---------------------------------------------------------------------------
	// FSM
	// ---------------------------------------------------------------------------
	always_ff @(posedge sys_clk_i) begin
		if (!rst1_i) begin
			state_q <= memsys_pkg::IDLE;
		end else begin
			case (state_q)
				// Wait for host request
				memsys_pkg::IDLE:
					if (req_i) state_q <= memsys_pkg::ISSUE;
				// stb out, waiting on the arbiter and memory
				memsys_pkg::ISSUE:
					if (bus.ack) state_q <= memsys_pkg::HOLD;
				// Done, host may keep req high as long as it likes
				memsys_pkg::HOLD:
					if (!req_i) state_q <= memsys_pkg::RELEASE;
				// ack_o low for one cycle before the next request
				memsys_pkg::RELEASE:
					state_q <= memsys_pkg::IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------------
	// Command and result registers
	// ---------------------------------------------------------------------------
	always_ff @(posedge sys_clk_i) begin
		// Latch command as req is accepted
		if (state_q == memsys_pkg::IDLE && req_i) begin
			we_q    <= we_i;
			addr_q  <= addr_i;
			sel_q   <= sel_i;
			wdata_q <= wdata_i;
		end
		// rdata only valid in the ack cycle
		if (state_q == memsys_pkg::ISSUE && bus.ack) begin
			rdata_q <= bus.rdata;
		end
	end

	// Bus side, stb tracks ISSUE so it drops the cycle after ack
	assign bus.stb   = (state_q == memsys_pkg::ISSUE);
	assign bus.we    = we_q;
	assign bus.addr  = addr_q;
	assign bus.sel   = sel_q;
	assign bus.wdata = wdata_q;

	// Host side
	assign ack_o   = (state_q == memsys_pkg::HOLD);
	assign rdata_o = rdata_q;

endmodule

// ==== src/sram_ctrl.sv ====
// On-chip word memory with byte-select writes and fixed-latency ack, with assertions
`include "memsys_consts.svh"

module sram_ctrl (
	input  logic      sys_clk_i,
	input  logic      rst1_i,
	mem_port_if.slave bus
);

	// Counter wide enough to reach the latency value
	typedef logic [$clog2(`MEMSYS_RD_LAT+1)-1:0] lat_cnt_t;

	memsys_pkg::mem_word_t mem_q [`MEMSYS_DEPTH];

	lat_cnt_t lat_cnt;
	logic     ack_q;
	logic     fire;

	memsys_pkg::mem_word_t rdata_q;

	// Access completes once the count hits the latency
	// Held stb in the ack cycle must not start a new access
	assign fire = bus.stb && !ack_q && (lat_cnt == lat_cnt_t'(`MEMSYS_RD_LAT));

	// ---------------------------------------------------------------------------
	// Latency counter and ack
	// ---------------------------------------------------------------------------
	always_ff @(posedge sys_clk_i) begin
		if (!rst1_i) begin
			lat_cnt <= '0;
			ack_q   <= 1'b0;
		end else begin
			ack_q <= fire;
			if (fire || !bus.stb || ack_q) begin
				lat_cnt <= '0;
			end else begin
				lat_cnt <= lat_cnt + lat_cnt_t'(1);
			end
		end
	end

	// ---------------------------------------------------------------------------
	// Storage
	// ---------------------------------------------------------------------------
	always_ff @(posedge sys_clk_i) begin
		if (fire) begin
			// Old word on a write, new data shows on the next access
			rdata_q <= mem_q[bus.addr];
			if (bus.we) begin
				for (int i = 0; i < `MEMSYS_SEL_W; i++) begin
					// Only selected lanes
					if (bus.sel[i]) begin
						mem_q[bus.addr][i*8 +: 8] <= bus.wdata[i*8 +: 8];
					end
				end
			end
		end
	end

	assign bus.ack   = ack_q;
	assign bus.rdata = rdata_q;

	// One-cycle ack pulse
	a_ack_pulse: assert property (@(posedge sys_clk_i) disable iff (!rst1_i)
		bus.ack |=> !bus.ack);

	// Master side keeps stb up until answered
	a_stb_held: assert property (@(posedge sys_clk_i) disable iff (!rst1_i)
		(bus.stb && !bus.ack) |=> bus.stb);

endmodule
